//--- source/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

`define CPU_WORD_WIDTH       32
`define CPU_REG_COUNT        8
`define CPU_REG_INDEX_WIDTH  3
`define CPU_OPCODE_WIDTH     4
`define CPU_RESET_PC         32'h0000_0000

// opcodes in the top four bits of the instruction word.
`define CPU_OP_ADD    4'h0
`define CPU_OP_SUB    4'h1
`define CPU_OP_AND    4'h2
`define CPU_OP_OR     4'h3
`define CPU_OP_XOR    4'h4
`define CPU_OP_ADDI   4'h5
`define CPU_OP_LUI    4'h6
`define CPU_OP_LOAD   4'h7
`define CPU_OP_STORE  4'h8
`define CPU_OP_BZ     4'h9
`define CPU_OP_BNZ    4'ha
`define CPU_OP_HALT   4'hf

`endif

//--- source/cpu_pkg.sv
`include "cpu_defs.svh"

package cpu_pkg;

    // register-register view.
    typedef struct packed {
        logic [`CPU_OPCODE_WIDTH-1:0]    opcode;
        logic [`CPU_REG_INDEX_WIDTH-1:0] rd;
        logic [`CPU_REG_INDEX_WIDTH-1:0] ra;
        logic [`CPU_REG_INDEX_WIDTH-1:0] rb;
        logic [18:0]                     unused;
    } r_form_t;

    // immediate view used by addi, lui, loads, stores and branches.
    typedef struct packed {
        logic [`CPU_OPCODE_WIDTH-1:0]    opcode;
        logic [`CPU_REG_INDEX_WIDTH-1:0] rd;
        logic [`CPU_REG_INDEX_WIDTH-1:0] ra;
        logic [5:0]                      spare;
        logic [15:0]                     imm;
    } i_form_t;

    typedef union packed {
        r_form_t r;
        i_form_t i;
    } instr_word_t;

    // everything the bus master drives.
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`CPU_WORD_WIDTH-1:0] adr;
        logic [`CPU_WORD_WIDTH-1:0] dat;
    } wb_request_t;

    typedef struct packed {
        logic                       ack;
        logic [`CPU_WORD_WIDTH-1:0] dat;
    } wb_response_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_PASS_B
    } alu_op_t;

    typedef enum logic [1:0] {
        STATE_FETCH,
        STATE_EXECUTE,
        STATE_MEMORY,
        STATE_HALTED
    } control_state_t;

endpackage

//--- source/alu.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module alu
    import cpu_pkg::*;
(
    input  alu_op_t                    op,
    input  logic [`CPU_WORD_WIDTH-1:0] operand_a,
    input  logic [`CPU_WORD_WIDTH-1:0] operand_b,
    output logic [`CPU_WORD_WIDTH-1:0] result,
    output logic                       zero
);

    always_comb
    begin
        case (op)
            ALU_ADD:
            begin
                result = operand_a + operand_b;   // wraps at 32 bits.
            end
            ALU_SUB:
            begin
                result = operand_a - operand_b;
            end
            ALU_AND:
            begin
                result = operand_a & operand_b;
            end
            ALU_OR:
            begin
                result = operand_a | operand_b;
            end
            ALU_XOR:
            begin
                result = operand_a ^ operand_b;
            end
            ALU_PASS_B:
            begin
                result = operand_b;   // lui and load data.
            end
            default:
            begin
                result = operand_b;
            end
        endcase
    end

    // becomes the destination flag.
    assign zero = (result == '0);

endmodule

//--- source/register_file.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module register_file (
    input  logic                           clock,
    input  logic                           reset,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] read_index_a,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] read_index_b,
    output logic [`CPU_WORD_WIDTH-1:0]      read_data_a,
    output logic [`CPU_WORD_WIDTH-1:0]      read_data_b,
    output logic                           flag_a,
    input  logic                           write_enable,
    input  logic [`CPU_REG_INDEX_WIDTH-1:0] write_index,
    input  logic [`CPU_WORD_WIDTH-1:0]      write_data,
    input  logic                           write_flag
);

    logic [`CPU_WORD_WIDTH-1:0] registers [`CPU_REG_COUNT];
    logic [`CPU_REG_COUNT-1:0]  flags;   // one zero flag per register.

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < `CPU_REG_COUNT; i++)
            begin
                registers[i] <= '0;
            end
            flags <= '0;
        end
        else if (write_enable)
        begin
            registers[write_index] <= write_data;
            flags[write_index]     <= write_flag;   // flag follows every write.
        end
    end

    // asynchronous reads.
    assign read_data_a = registers[read_index_a];
    assign read_data_b = registers[read_index_b];
    assign flag_a      = flags[read_index_a];

endmodule

//--- source/cpu_control.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_control
    import cpu_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,
    input  wb_response_t                    wb_response,
    output wb_request_t                     wb_request,
    output logic                            halted,
    output logic [`CPU_REG_INDEX_WIDTH-1:0] read_index_a,
    output logic [`CPU_REG_INDEX_WIDTH-1:0] read_index_b,
    input  logic [`CPU_WORD_WIDTH-1:0]      read_data_a,
    input  logic [`CPU_WORD_WIDTH-1:0]      read_data_b,
    input  logic                            flag_a,
    output alu_op_t                         alu_op,
    output logic [`CPU_WORD_WIDTH-1:0]      alu_operand_a,
    output logic [`CPU_WORD_WIDTH-1:0]      alu_operand_b,
    input  logic [`CPU_WORD_WIDTH-1:0]      alu_result,
    output logic                            write_enable,
    output logic [`CPU_REG_INDEX_WIDTH-1:0] write_index,
    output logic [`CPU_WORD_WIDTH-1:0]      write_data
);

    control_state_t                  state;
    logic [`CPU_WORD_WIDTH-1:0]      pc;
    instr_word_t                     instr;
    logic [`CPU_OPCODE_WIDTH-1:0]    opcode;
    logic [`CPU_WORD_WIDTH-1:0]      imm_sext;
    logic [`CPU_WORD_WIDTH-1:0]      pc_next;
    logic [`CPU_WORD_WIDTH-1:0]      branch_target;

    assign opcode        = instr.r.opcode;
    assign imm_sext      = {{16{instr.i.imm[15]}}, instr.i.imm};
    assign pc_next       = pc + 32'd4;
    assign branch_target = pc_next + {imm_sext[`CPU_WORD_WIDTH-3:0], 2'b00};

    // a store reads its data register through port b.
    assign read_index_a  = instr.r.ra;
    assign read_index_b  = (opcode == `CPU_OP_STORE) ? instr.i.rd : instr.r.rb;
    assign alu_operand_a = read_data_a;
    assign write_index   = instr.i.rd;
    assign write_data    = alu_result;
    assign halted        = (state == STATE_HALTED);

    always_comb
    begin
        alu_op        = ALU_PASS_B;
        alu_operand_b = read_data_b;
        write_enable  = 1'b0;
        if (state == STATE_EXECUTE)
        begin
            case (opcode)
                `CPU_OP_ADD:
                begin
                    alu_op       = ALU_ADD;
                    write_enable = 1'b1;
                end
                `CPU_OP_SUB:
                begin
                    alu_op       = ALU_SUB;
                    write_enable = 1'b1;
                end
                `CPU_OP_AND:
                begin
                    alu_op       = ALU_AND;
                    write_enable = 1'b1;
                end
                `CPU_OP_OR:
                begin
                    alu_op       = ALU_OR;
                    write_enable = 1'b1;
                end
                `CPU_OP_XOR:
                begin
                    alu_op       = ALU_XOR;
                    write_enable = 1'b1;
                end
                `CPU_OP_ADDI:
                begin
                    alu_op        = ALU_ADD;
                    alu_operand_b = imm_sext;
                    write_enable  = 1'b1;
                end
                `CPU_OP_LUI:
                begin
                    alu_operand_b = {instr.i.imm, 16'h0000};
                    write_enable  = 1'b1;
                end
                `CPU_OP_LOAD, `CPU_OP_STORE:
                begin
                    alu_op        = ALU_ADD;   // effective address.
                    alu_operand_b = imm_sext;
                end
                default:
                begin
                    alu_op = ALU_PASS_B;
                end
            endcase
        end
        else if (state == STATE_MEMORY)
        begin
            // load data runs through the alu so its zero flag is written too.
            alu_operand_b = wb_response.dat;
            write_enable  = wb_request.cyc & wb_response.ack & ~wb_request.we;
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state          <= STATE_FETCH;
            pc             <= `CPU_RESET_PC;
            wb_request.cyc <= 1'b0;
            wb_request.stb <= 1'b0;
            wb_request.we  <= 1'b0;
        end
        else
        begin
            case (state)
                STATE_FETCH:
                begin
                    if (!wb_request.cyc)
                    begin
                        wb_request.cyc <= 1'b1;
                        wb_request.stb <= 1'b1;
                        wb_request.we  <= 1'b0;
                        wb_request.adr <= pc;
                    end
                    else if (wb_response.ack)
                    begin
                        instr          <= wb_response.dat;
                        wb_request.cyc <= 1'b0;
                        wb_request.stb <= 1'b0;
                        state          <= STATE_EXECUTE;
                    end
                end
                STATE_EXECUTE:
                begin
                    case (opcode)
                        `CPU_OP_LOAD, `CPU_OP_STORE:
                        begin
                            wb_request.cyc <= 1'b1;
                            wb_request.stb <= 1'b1;
                            wb_request.we  <= (opcode == `CPU_OP_STORE);
                            wb_request.adr <= alu_result;
                            wb_request.dat <= read_data_b;
                            pc             <= pc_next;
                            state          <= STATE_MEMORY;
                        end
                        `CPU_OP_BZ:
                        begin
                            pc    <= flag_a ? branch_target : pc_next;
                            state <= STATE_FETCH;
                        end
                        `CPU_OP_BNZ:
                        begin
                            pc    <= flag_a ? pc_next : branch_target;
                            state <= STATE_FETCH;
                        end
                        `CPU_OP_HALT:
                        begin
                            state <= STATE_HALTED;   // pc stays on the halt.
                        end
                        default:
                        begin
                            pc    <= pc_next;
                            state <= STATE_FETCH;
                        end
                    endcase
                end
                STATE_MEMORY:
                begin
                    if (wb_response.ack)
                    begin
                        wb_request.cyc <= 1'b0;
                        wb_request.stb <= 1'b0;
                        wb_request.we  <= 1'b0;
                        state          <= STATE_FETCH;
                    end
                end
                default:
                begin
                    state <= STATE_HALTED;   // only reset leaves.
                end
            endcase
        end
    end

endmodule

//--- source/cpu_core.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_core
    import cpu_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  wb_response_t wb_response,
    output wb_request_t  wb_request,
    output logic         halted
);

    logic [`CPU_REG_INDEX_WIDTH-1:0] read_index_a;
    logic [`CPU_REG_INDEX_WIDTH-1:0] read_index_b;
    logic [`CPU_REG_INDEX_WIDTH-1:0] write_index;
    logic [`CPU_WORD_WIDTH-1:0]      read_data_a;
    logic [`CPU_WORD_WIDTH-1:0]      read_data_b;
    logic [`CPU_WORD_WIDTH-1:0]      alu_operand_a;
    logic [`CPU_WORD_WIDTH-1:0]      alu_operand_b;
    logic [`CPU_WORD_WIDTH-1:0]      alu_result;
    logic [`CPU_WORD_WIDTH-1:0]      write_data;
    logic                            flag_a;
    logic                            alu_zero;
    logic                            write_enable;
    alu_op_t                         alu_op;

    cpu_control control (
        .clock         (clock),
        .reset         (reset),
        .wb_response   (wb_response),
        .wb_request    (wb_request),
        .halted        (halted),
        .read_index_a  (read_index_a),
        .read_index_b  (read_index_b),
        .read_data_a   (read_data_a),
        .read_data_b   (read_data_b),
        .flag_a        (flag_a),
        .alu_op        (alu_op),
        .alu_operand_a (alu_operand_a),
        .alu_operand_b (alu_operand_b),
        .alu_result    (alu_result),
        .write_enable  (write_enable),
        .write_index   (write_index),
        .write_data    (write_data)
    );

    register_file registers (
        .clock        (clock),
        .reset        (reset),
        .read_index_a (read_index_a),
        .read_index_b (read_index_b),
        .read_data_a  (read_data_a),
        .read_data_b  (read_data_b),
        .flag_a       (flag_a),
        .write_enable (write_enable),
        .write_index  (write_index),
        .write_data   (write_data),
        .write_flag   (alu_zero)   // zero of the written value.
    );

    alu arith (
        .op        (alu_op),
        .operand_a (alu_operand_a),
        .operand_b (alu_operand_b),
        .result    (alu_result),
        .zero      (alu_zero)
    );

endmodule

//--- tb/bus_memory_model.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module bus_memory_model
    import cpu_pkg::*;
(
    input  logic         clock,
    input  logic         reset,
    input  wb_request_t  request,
    output wb_response_t response
);

    logic [`CPU_WORD_WIDTH-1:0] image  [0:511];
    logic [`CPU_WORD_WIDTH-1:0] memory [0:255];
    logic [7:0]                 word_index;
    logic                       ack;
    logic                       pending;
    int                         wait_count;

    initial
    begin
        for (int i = 0; i < 512; i++)
        begin
            image[i] = 32'hc0de_0000 | i;   // words the file leaves out.
        end
        $readmemh("tb/cpu_vectors.txt", image);
        for (int i = 0; i < 256; i++)
        begin
            memory[i] = image[i];
        end
    end

    assign word_index = request.adr[9:2];
    assign response   = {ack, memory[word_index]};

    always @(posedge clock)
    begin
        if (reset)
        begin
            ack        <= 1'b0;
            pending    <= 1'b0;
            wait_count <= 0;
        end
        else if (ack)
        begin
            ack <= 1'b0;   // master drops cyc on the same edge.
        end
        else if (request.cyc && request.stb)
        begin
            if (!pending)
            begin
                pending    <= 1'b1;
                wait_count <= $urandom_range(3, 0);
            end
            else if (wait_count == 0)
            begin
                ack     <= 1'b1;
                pending <= 1'b0;
                if (request.we)
                begin
                    memory[word_index] <= request.dat;
                    $display("store %h to %h", request.dat, request.adr);
                end
            end
            else
            begin
                wait_count <= wait_count - 1;
            end
        end
    end

endmodule

//--- tb/cpu_core_tb.sv
`timescale 1ns/10ps
`include "cpu_defs.svh"

module cpu_core_tb
    import cpu_pkg::*;
();

    logic         clock;
    logic         reset;
    wb_request_t  wb_request;
    wb_response_t wb_response;
    logic         halted;

    logic [`CPU_WORD_WIDTH-1:0] vectors [0:511];
    logic [`CPU_WORD_WIDTH-1:0] halt_address;
    logic [`CPU_WORD_WIDTH-1:0] last_read_address;
    logic [`CPU_WORD_WIDTH-1:0] last_read_data;
    wb_request_t                held_request;
    int                         program_words;
    int                         store_count;
    int                         timeout_limit;
    int                         cycle_count;
    int unsigned                seed_draw;
    int                         seed        = 21;
    int                         errors      = 0;
    int                         store_index = 0;
    logic                       waiting     = 1'b0;
    logic                       fetch_seen  = 1'b0;
    logic                       halt_seen   = 1'b0;

    cpu_core uut (
        .clock       (clock),
        .reset       (reset),
        .wb_response (wb_response),
        .wb_request  (wb_request),
        .halted      (halted)
    );

    bus_memory_model bus_memory (
        .clock    (clock),
        .reset    (reset),
        .request  (wb_request),
        .response (wb_response)
    );

    initial
    begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    task automatic compare_word(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        assert (actual === expected)
        else
        begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic record_store(input logic [31:0] adr, input logic [31:0] dat);
        assert (store_index < store_count)
        else
        begin
            errors++;
            $display("unexpected extra store of %h to %h", dat, adr);
        end
        if (store_index < store_count)
        begin
            compare_word("wb_request.adr", adr, vectors[259 + 2 * store_index]);
            compare_word("wb_request.dat", dat, vectors[260 + 2 * store_index]);
        end
        store_index++;
    endtask

    // bus watcher sampling on the falling edge.
    always @(negedge clock)
    begin
        if (!reset)
        begin
            if (wb_request.cyc && wb_request.stb)
            begin
                if (!fetch_seen)
                begin
                    compare_word("first fetch wb_request.adr", wb_request.adr, `CPU_RESET_PC);
                    fetch_seen = 1'b1;
                end
                if (waiting)
                begin
                    compare_word("held wb_request.adr", wb_request.adr, held_request.adr);
                    compare_word("held wb_request.dat", wb_request.dat, held_request.dat);
                    compare_word("held wb_request.we", wb_request.we, held_request.we);
                end
                if (wb_response.ack)
                begin
                    waiting = 1'b0;
                    if (wb_request.we)
                    begin
                        record_store(wb_request.adr, wb_request.dat);
                    end
                    else
                    begin
                        last_read_address = wb_request.adr;   // the halt fetch ends up here.
                        last_read_data    = wb_response.dat;
                    end
                end
                else
                begin
                    waiting      = 1'b1;
                    held_request = wb_request;
                end
            end
            else
            begin
                waiting = 1'b0;
            end
            if (halted === 1'b1)
            begin
                halt_seen = 1'b1;
            end
            if (halt_seen)
            begin
                assert (halted === 1'b1)
                else
                begin
                    errors++;
                    $display("halted dropped after the core halted");
                end
                assert (wb_request.cyc === 1'b0)
                else
                begin
                    errors++;
                    $display("bus cycle started after the core halted");
                end
            end
        end
    end

    initial
    begin
        reset     = 1'b1;
        seed_draw = $urandom(seed);
        $readmemh("tb/cpu_vectors.txt", vectors);
        program_words = vectors[256];
        store_count   = vectors[257];
        halt_address  = vectors[258];
        timeout_limit = program_words * 16 * 3;   // 16 cycles per word for 3 bus accesses.
        repeat (16)
        begin
            @(negedge clock);
            assert (wb_request.cyc === 1'b0 && wb_request.stb === 1'b0 && halted === 1'b0)
            else
            begin
                errors++;
                $display("cyc, stb or halted not low during reset");
            end
        end
        reset = 1'b0;
        cycle_count = 0;
        while (halted !== 1'b1 && cycle_count < timeout_limit)
        begin
            @(negedge clock);
            cycle_count++;
        end
        if (halted !== 1'b1)
        begin
            errors++;
            $display("core never halted within %0d cycles", timeout_limit);
        end
        else
        begin
            repeat (20) @(negedge clock);   // bus must stay idle.
            compare_word("last fetch wb_request.adr", last_read_address, halt_address);
            assert (store_index == store_count)
            else
            begin
                errors++;
                $display("saw %0d stores where %0d were expected", store_index, store_count);
            end
            assert (last_read_data[31:28] == `CPU_OP_HALT)
            else
            begin
                errors++;
                $display("core halted after fetching a word that is not a halt instruction");
            end
        end
        $display("%0d errors, %0d of %0d stores seen, %0d cycles", errors, store_index,
                 store_count, cycle_count);
        if (errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

//--- files.f
+incdir+source
source/cpu_pkg.sv
source/alu.sv
source/register_file.sv
source/cpu_control.sv
source/cpu_core.sv
tb/bus_memory_model.sv
tb/cpu_core_tb.sv

//--- tb/cpu_vectors.txt
// program image from word 0 (two instruction words per line), zero data word at 0x240,
// then from word 0x100: program words, store count, halt address, store adr/dat pairs.
@000
52001234 6400abcd  // addi r1,r0,0x1234    lui r2,0xabcd
54805678 5600ffff  // addi r2,r2,0x5678    addi r3,r0,-1
08980000 88000200  // add r4,r2,r3         store r4,0x200(r0)
1a500000 8a000204  // sub r5,r1,r2         store r5,0x204(r0)
2ca00000 8c000208  // and r6,r2,r4         store r6,0x208(r0)
3e500000 8e00020c  // or r7,r1,r2          store r7,0x20c(r0)
4dd80000 8c000210  // xor r6,r7,r3         store r6,0x210(r0)
7e000200 5fc00009  // load r7,0x200(r0)    addi r7,r7,9
8e000214 5a000220  // store r7,0x214(r0)   addi r5,r0,0x220
8f40fff8 1c480000  // store r7,-8(r5)      sub r6,r1,r1
91800001 8600021c  // bz r6,+1 taken       store r3 never runs
a0400001 8600021c  // bnz r1,+1 taken      store r3 never runs
90400005 8200021c  // bz r1,+5 falls thru  store r1,0x21c(r0)
74000240 90800001  // load r2,0x240(r0)    bz r2,+1 taken
86000224 a0800001  // store r3 never runs  bnz r2,+1 falls thru
88000224 f0000000  // store r4,0x224(r0)   halt
@090
00000000           // zero word at 0x240
@100
00000020 00000009 0000007c  // program words, store count, halt address
00000200 abcd5677
00000204 5432bbbc
00000208 abcd5670
0000020c abcd567c
00000210 5432a983
00000214 abcd5680
00000218 abcd5680
0000021c 00001234
00000224 abcd5677
